//--- disp_bus_top.f
+incdir+.
disp_bus_pkg.sv
bus_arbiter.sv
bus_master_port.sv
bus_slave_port.sv
disp_cfg_regs.sv
display_node.sv
bcd_seg_decoder.sv
disp_bus_top.sv
disp_bus_properties.sv
disp_bus_tb.sv

//--- disp_bus_tb.sv
/*
 * Display bus testbench
 * Plays the external master and the forwarding target around the display node
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module disp_bus_tb
    import disp_bus_pkg::*;
();

    localparam int CYCLE_LIMIT = 6 * (2 * `DB_FRAME_LEN + 300);

    logic                  clk;
    logic                  rstn;
    logic                  ext_req;
    logic                  ext_grant;
    sbus_t                 ext_bus;
    sbus_t                 bus;
    disp_digits_t          digits;
    logic                  node_busy;

    logic [31:0]           lfsr;
    int                    cycles;
    int                    errors;
    int                    test_errors;
    int                    tests;
    int                    exp_holdoff;
    logic [`DB_ID_W-1:0]   exp_fwd_id;
    logic [`DB_DATA_W-1:0] shown;           // Byte the display should hold

    disp_bus_top disp_bus_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .ext_req   (ext_req),
        .ext_grant (ext_grant),
        .ext_bus   (ext_bus),
        .bus       (bus),
        .digits    (digits),
        .node_busy (node_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //----------------------------------------
    // Stimulus and reference model
    //----------------------------------------
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    function automatic seg_t digit_segments(input int d);
        case (d)
            0:       return 7'b1111110;
            1:       return 7'b0110000;
            2:       return 7'b1101101;
            3:       return 7'b1111001;
            4:       return 7'b0110011;
            5:       return 7'b1011011;
            6:       return 7'b1011111;
            7:       return 7'b1110000;
            8:       return 7'b1111111;
            9:       return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic disp_digits_t expected_digits(input logic [7:0] v);
        disp_digits_t e;
        e[0] = digit_segments(v % 10);
        e[1] = digit_segments((v / 10) % 10);
        e[2] = digit_segments(v / 100);
        return e;
    endfunction

    function automatic xfer_t build_write(input logic [2:0] id, input logic [11:0] idx,
                                          input logic [7:0] data);
        return '{addr: {id, idx}, data: data};
    endfunction

    function automatic xfer_t expected_forward(input logic [7:0] v);
        return '{addr: {exp_fwd_id, {`DB_IDX_W{1'b0}}}, data: 8'(v + 8'd1)};
    endfunction

    //----------------------------------------
    // Compare and report
    //----------------------------------------
    task automatic compare_digits(input string name, input disp_digits_t got,
                                  input disp_digits_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_xfer(input string name, input xfer_t got, input xfer_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0)
            $display("test %-12s ok", name);
        else
            $display("test %-12s %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    //----------------------------------------
    // Bus models
    //----------------------------------------
    task automatic send_frame(input xfer_t f);
        logic [`DB_FRAME_LEN-1:0] bits;
        bits = f;
        @(posedge clk);
        ext_req <= 1'b1;
        do
            @(negedge clk);
        while (!ext_grant);
        compare_bit("bus.util at ext_grant", bus.util, 1'b0);
        for (int i = `DB_FRAME_LEN - 1; i >= 0; i--)
        begin
            @(posedge clk);
            ext_bus <= '{util: 1'b1, sdata: bits[i]};     // MSB first
        end
        @(posedge clk);
        ext_bus <= '0;
        ext_req <= 1'b0;
    endtask

    task automatic capture_frame(output xfer_t f);
        logic [`DB_FRAME_LEN-1:0] bits;
        bits = '0;
        while (!bus.util)
            @(negedge clk);
        for (int i = 0; i < `DB_FRAME_LEN; i++)
        begin
            if (!bus.util)
                report_failure($sformatf("node frame ended after %0d bits", i));
            bits = {bits[`DB_FRAME_LEN-2:0], bus.sdata};
            @(negedge clk);
        end
        if (bus.util)
            report_failure("node frame ran past its last bit");
        f = bits;
    endtask

    // Returns at the first cycle of the forward frame
    task automatic write_display(input logic [7:0] v, output int req_delay,
                                 output int start_delay);
        int n;
        send_frame(build_write(`DB_SELF_ID, `DB_REG_DISP, v));
        do
            @(negedge clk);
        while (!disp_bus_top_i.reg_wr.valid);
        @(negedge clk);
        n = 1;
        shown = v;
        compare_digits("digits", digits, expected_digits(v));
        compare_bit("node_busy", node_busy, 1'b1);
        while (!disp_bus_top_i.xfer_req)
        begin
            @(negedge clk);
            n++;
        end
        req_delay = n;
        while (!bus.util)
        begin
            @(negedge clk);
            n++;
        end
        start_delay = n;
    endtask

    task automatic wait_idle();
        do
            @(negedge clk);
        while (node_busy || disp_bus_top_i.xfer_ack);
        @(negedge clk);
    endtask

    //----------------------------------------
    // Directed tests
    //----------------------------------------
    task automatic test_reset();
        compare_digits("digits", digits, expected_digits(8'd0));
        compare_bit("node_busy", node_busy, 1'b0);
        compare_bit("ext_grant", ext_grant, 1'b0);
        compare_bit("bus.util", bus.util, 1'b0);
        compare_bit("xfer_req", disp_bus_top_i.xfer_req, 1'b0);
        finish_test("reset");
    endtask

    task automatic test_display();
        xfer_t      got;
        int         req_delay;
        int         start_delay;
        logic [7:0] v;
        repeat (3)
        begin
            v = rand_byte();
            write_display(v, req_delay, start_delay);
            compare_count("xfer_req delay", req_delay, exp_holdoff + 1);
            capture_frame(got);
            compare_xfer("forward frame", got, expected_forward(v));
            wait_idle();
        end
        finish_test("display");
    endtask

    task automatic test_forward();
        xfer_t      got;
        int         req_delay;
        int         start_delay;
        logic [7:0] v;
        for (int k = 0; k < 2; k++)
        begin
            v = (k == 0) ? rand_byte() : 8'hFF;         // Second pass wraps
            write_display(v, req_delay, start_delay);
            compare_count("xfer_req delay", req_delay, exp_holdoff + 1);
            capture_frame(got);
            compare_xfer("forward frame", got, expected_forward(v));
            wait_idle();
        end
        finish_test("forward");
    endtask

    task automatic test_config();
        xfer_t      got;
        int         req_delay;
        int         start_delay;
        logic [7:0] v;
        send_frame(build_write(`DB_SELF_ID, `DB_REG_HOLDOFF, 8'd5));
        send_frame(build_write(`DB_SELF_ID, `DB_REG_FWD, 8'hF6));
        exp_holdoff = 5;
        exp_fwd_id  = 3'd6;
        v = rand_byte();
        write_display(v, req_delay, start_delay);
        compare_count("xfer_req delay", req_delay, exp_holdoff + 1);
        if (start_delay < exp_holdoff + 1)
            report_failure($sformatf("forward began only %0d cycles after the write",
                                     start_delay));
        capture_frame(got);
        compare_xfer("forward frame", got, expected_forward(v));
        wait_idle();
        finish_test("config");
    endtask

    task automatic test_contention();
        xfer_t      got;
        int         req_delay;
        int         start_delay;
        logic [7:0] v;
        v = rand_byte();
        write_display(v, req_delay, start_delay);
        fork
            capture_frame(got);
            send_frame(build_write(3'd5, `DB_REG_DISP, rand_byte()));
        join
        compare_xfer("forward frame", got, expected_forward(v));
        wait_idle();
        finish_test("contention");
    endtask

    task automatic test_other_ids();
        logic quiet;
        quiet = 1'b1;
        for (int k = 0; k < 2; k++)
        begin
            send_frame(build_write((k == 0) ? 3'd3 : 3'd7, `DB_REG_DISP, rand_byte()));
            repeat (3)
            begin
                @(negedge clk);
                quiet = quiet && !disp_bus_top_i.reg_wr.valid;
            end
        end
        repeat (60)
        begin
            @(negedge clk);
            quiet = quiet && !bus.util && !node_busy;
        end
        if (!quiet)
            report_failure("node reacted to a write for another node id");
        compare_digits("digits", digits, expected_digits(shown));
        finish_test("other_ids");
    endtask

    initial
    begin
        rstn        = 1'b0;
        ext_req     = 1'b0;
        ext_bus     = '0;
        lfsr        = 32'h2609_7acd;
        cycles      = 0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        shown       = '0;
        exp_holdoff = `DB_HOLDOFF_RST;
        exp_fwd_id  = `DB_FWD_ID_RST;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        test_reset();
        test_display();
        test_forward();
        test_config();
        test_contention();
        test_other_ids();
        errors += disp_bus_top_i.disp_bus_properties_i.failures;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- disp_bus_properties.sv
/*
 * Display bus protocol properties
 * Grant exclusion, frame length and the node-to-port transfer handshake
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module disp_bus_properties
    import disp_bus_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  ext_grant,
    input logic  node_grant,
    input sbus_t bus,
    input logic  xfer_req,
    input logic  xfer_ack
);

    int failures = 0;                       // Failed assertion count

    // One owner at a time
    grant_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(ext_grant && node_grant))
        else
        begin
            $error("ext_grant and node_grant high together");
            failures++;
        end

    frame_length: assert property (@(posedge clk) disable iff (!rstn)
        $rose(bus.util) |-> bus.util [*`DB_FRAME_LEN] ##1 !bus.util)
        else
        begin
            $error("util high for other than one frame length");
            failures++;
        end

    //----------------------------------------
    // Four-phase transfer handshake
    //----------------------------------------
    req_held: assert property (@(posedge clk) disable iff (!rstn)
        xfer_req && !xfer_ack |=> xfer_req)
        else
        begin
            $error("xfer_req dropped before xfer_ack");
            failures++;
        end

    ack_held: assert property (@(posedge clk) disable iff (!rstn)
        xfer_ack && xfer_req |=> xfer_ack)   // Ack waits for the request to fall
        else
        begin
            $error("xfer_ack dropped while xfer_req high");
            failures++;
        end

endmodule

bind disp_bus_top disp_bus_properties disp_bus_properties_i (
    .clk        (clk),
    .rstn       (rstn),
    .ext_grant  (ext_grant),
    .node_grant (node_grant),
    .bus        (bus),
    .xfer_req   (xfer_req),
    .xfer_ack   (xfer_ack)
);

//--- disp_bus_top.sv
/*
 * Display bus top
 * Display node with its bus ports, config registers, decoder and arbiter
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module disp_bus_top
    import disp_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         ext_req,
    output logic         ext_grant,
    input  sbus_t        ext_bus,
    output sbus_t        bus,
    output disp_digits_t digits,
    output logic         node_busy
);

    logic                  node_req;
    logic                  node_grant;
    sbus_t                 node_bus;
    reg_wr_t               reg_wr;
    node_cfg_t             cfg;
    xfer_t                 xfer;
    logic                  xfer_req;
    logic                  xfer_ack;
    logic [`DB_DATA_W-1:0] disp_value;

    // Idle drivers sit at zero, so OR merges them
    assign bus = sbus_t'(ext_bus | node_bus);

    bus_arbiter bus_arbiter_i (
        .clk        (clk),
        .rstn       (rstn),
        .ext_req    (ext_req),
        .node_req   (node_req),
        .ext_grant  (ext_grant),
        .node_grant (node_grant)
    );

    bus_master_port bus_master_port_i (
        .clk       (clk),
        .rstn      (rstn),
        .xfer_req  (xfer_req),
        .xfer      (xfer),
        .xfer_ack  (xfer_ack),
        .bus_req   (node_req),
        .bus_grant (node_grant),
        .bus_out   (node_bus)
    );

    bus_slave_port bus_slave_port_i (
        .clk    (clk),
        .rstn   (rstn),
        .bus_in (bus),
        .reg_wr (reg_wr)
    );

    disp_cfg_regs disp_cfg_regs_i (
        .clk    (clk),
        .rstn   (rstn),
        .reg_wr (reg_wr),
        .cfg    (cfg)
    );

    display_node display_node_i (
        .clk        (clk),
        .rstn       (rstn),
        .reg_wr     (reg_wr),
        .cfg        (cfg),
        .disp_value (disp_value),
        .xfer_req   (xfer_req),
        .xfer       (xfer),
        .xfer_ack   (xfer_ack),
        .node_busy  (node_busy)
    );

    bcd_seg_decoder bcd_seg_decoder_i (
        .value  (disp_value),
        .digits (digits)
    );

endmodule

//--- bcd_seg_decoder.sv
/*
 * BCD and seven-segment decoder
 * Splits a byte into three decimal digits and encodes each for display
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module bcd_seg_decoder
    import disp_bus_pkg::*;
(
    input  logic [`DB_DATA_W-1:0] value,
    output disp_digits_t          digits
);

    logic [11:0] bcd;                       // Hundreds, tens, ones

    function automatic seg_t seg_encode(input logic [3:0] d);
        case (d)
            4'd0:    seg_encode = 7'b1111110;
            4'd1:    seg_encode = 7'b0110000;
            4'd2:    seg_encode = 7'b1101101;
            4'd3:    seg_encode = 7'b1111001;
            4'd4:    seg_encode = 7'b0110011;
            4'd5:    seg_encode = 7'b1011011;
            4'd6:    seg_encode = 7'b1011111;
            4'd7:    seg_encode = 7'b1110000;
            4'd8:    seg_encode = 7'b1111111;
            4'd9:    seg_encode = 7'b1111011;
            default: seg_encode = 7'b0000000;
        endcase
    endfunction

    // Double dabble, one input bit per pass
    always_comb
    begin
        bcd = '0;
        for (int i = `DB_DATA_W - 1; i >= 0; i--)
        begin
            for (int d = 0; d < 3; d++)
            begin
                if (bcd[4*d +: 4] >= 4'd5)
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
            bcd = {bcd[10:0], value[i]};
        end
    end

    assign digits[0] = seg_encode(bcd[3:0]);
    assign digits[1] = seg_encode(bcd[7:4]);
    assign digits[2] = seg_encode(bcd[11:8]);

endmodule

//--- display_node.sv
/*
 * Display node
 * Holds the displayed byte and forwards it plus one after a hold-off
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module display_node
    import disp_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  reg_wr_t               reg_wr,
    input  node_cfg_t             cfg,
    output logic [`DB_DATA_W-1:0] disp_value,
    output logic                  xfer_req,
    output xfer_t                 xfer,
    input  logic                  xfer_ack,
    output logic                  node_busy
);

    typedef enum logic [1:0] {
        ND_IDLE,
        ND_HOLD,
        ND_SEND,
        ND_WAIT_ACK
    } nd_state_e;

    nd_state_e             state;
    logic [`DB_DATA_W-1:0] disp_buf;
    logic [`DB_HOLD_W-1:0] hold_cnt;
    logic                  disp_wr;

    assign disp_wr = reg_wr.valid && (reg_wr.index == `DB_REG_DISP);

    // Buffer follows every display write, busy or not
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            disp_buf <= '0;
        else if (disp_wr)
            disp_buf <= reg_wr.data;
    end

    //----------------------------------------
    // Forwarding FSM
    //----------------------------------------
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= ND_IDLE;
            hold_cnt  <= '0;
            xfer_req  <= 1'b0;
            node_busy <= 1'b0;
        end
        else
        begin
            case (state)
                ND_IDLE:
                begin
                    if (disp_wr)
                    begin
                        node_busy <= 1'b1;
                        hold_cnt  <= `DB_HOLD_W'(1);
                        if (cfg.holdoff == '0)
                        begin
                            xfer_req <= 1'b1;
                            state    <= ND_SEND;
                        end
                        else
                            state <= ND_HOLD;
                    end
                end
                ND_HOLD:
                begin
                    // Ack of a previous forward may still be high after a late write
                    if (hold_cnt >= cfg.holdoff)
                    begin
                        if (!xfer_ack)
                        begin
                            xfer_req <= 1'b1;
                            state    <= ND_SEND;
                        end
                    end
                    else
                        hold_cnt <= hold_cnt + 1'b1;
                end
                ND_SEND:
                begin
                    if (xfer_ack)
                    begin
                        xfer_req  <= 1'b0;
                        node_busy <= 1'b0;
                        state     <= ND_WAIT_ACK;
                    end
                end
                ND_WAIT_ACK:
                begin
                    if (disp_wr)
                    begin
                        node_busy <= 1'b1;
                        hold_cnt  <= `DB_HOLD_W'(1);
                        state     <= ND_HOLD;
                    end
                    else if (!xfer_ack)
                        state <= ND_IDLE;
                end
                default: state <= ND_IDLE;
            endcase
        end
    end

    assign disp_value = disp_buf;
    assign xfer.addr  = {cfg.fwd_id, {`DB_IDX_W{1'b0}}};
    assign xfer.data  = disp_buf + 1'b1;        // Wraps at 255

endmodule

//--- disp_cfg_regs.sv
/*
 * Node configuration registers
 * Forwarding hold-off and target node id, written over the bus
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module disp_cfg_regs
    import disp_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  reg_wr_t   reg_wr,
    output node_cfg_t cfg
);

    logic [`DB_HOLD_W-1:0] holdoff_q;
    logic [`DB_ID_W-1:0]   fwd_id_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            holdoff_q <= `DB_HOLDOFF_RST;
            fwd_id_q  <= `DB_FWD_ID_RST;
        end
        else if (reg_wr.valid)
        begin
            case (reg_wr.index)
                `DB_REG_HOLDOFF: holdoff_q <= reg_wr.data;
                `DB_REG_FWD:     fwd_id_q  <= reg_wr.data[`DB_ID_W-1:0];   // Low bits only
                default:         ;                                        // Display and others
            endcase
        end
    end

    assign cfg = '{holdoff: holdoff_q, fwd_id: fwd_id_q};

endmodule

//--- bus_slave_port.sv
/*
 * Bus slave port
 * Deserializes write frames and issues register writes addressed to this node
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module bus_slave_port
    import disp_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  sbus_t   bus_in,
    output reg_wr_t reg_wr
);

    localparam int FRAME_LEN = `DB_FRAME_LEN;
    localparam int CNT_W     = $clog2(FRAME_LEN);

    logic [FRAME_LEN-2:0]  shreg;           // All bits but the last
    logic [CNT_W-1:0]      bit_cnt;
    xfer_t                 rx;
    logic                  last_bit;
    logic                  id_hit;
    logic                  wr_valid;
    logic [`DB_IDX_W-1:0]  wr_index;
    logic [`DB_DATA_W-1:0] wr_data;

    // Full frame as it stands on the last bit
    assign rx       = {shreg, bus_in.sdata};
    assign last_bit = bus_in.util && (bit_cnt == CNT_W'(FRAME_LEN - 1));
    assign id_hit   = (rx.addr[`DB_ADDR_W-1 -: `DB_ID_W] == `DB_SELF_ID);

    //----------------------------------------
    // Bit counter and write strobe
    //----------------------------------------
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bit_cnt  <= '0;
            wr_valid <= 1'b0;
        end
        else
        begin
            wr_valid <= last_bit && id_hit;
            if (!bus_in.util || last_bit)
                bit_cnt <= '0;              // Short frames die here
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_in.util)
            shreg <= {shreg[FRAME_LEN-3:0], bus_in.sdata};
        if (last_bit)
        begin
            wr_index <= rx.addr[`DB_IDX_W-1:0];
            wr_data  <= rx.data;
        end
    end

    assign reg_wr = '{valid: wr_valid, index: wr_index, data: wr_data};

endmodule

//--- bus_master_port.sv
/*
 * Bus master port
 * Requests the bus and serializes one address-and-data write frame
 */
`timescale 1ns/1ps
`include "disp_bus_defines.svh"

module bus_master_port
    import disp_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  xfer_req,
    input  xfer_t xfer,
    output logic  xfer_ack,
    output logic  bus_req,
    input  logic  bus_grant,
    output sbus_t bus_out
);

    localparam int FRAME_LEN = `DB_FRAME_LEN;
    localparam int CNT_W     = $clog2(FRAME_LEN + 1);

    typedef enum logic [1:0] {
        MP_IDLE,
        MP_REQ,
        MP_SEND,
        MP_ACK
    } mp_state_e;

    mp_state_e            state;
    logic [FRAME_LEN-1:0] frame;
    logic [FRAME_LEN-1:0] shreg;
    logic [CNT_W-1:0]     bit_cnt;          // Bits already on the bus
    logic                 load;

    assign frame = xfer;
    assign load  = (state == MP_REQ) && bus_grant;

    // Frame shifter, first bit goes out straight from frame
    always_ff @(posedge clk)
    begin
        if (load)
            shreg <= {frame[FRAME_LEN-2:0], 1'b0};
        else if (state == MP_SEND)
            shreg <= {shreg[FRAME_LEN-2:0], 1'b0};
    end

    //----------------------------------------
    // Handshake and bit timing
    //----------------------------------------
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= MP_IDLE;
            bus_req  <= 1'b0;
            xfer_ack <= 1'b0;
            bus_out  <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            case (state)
                MP_IDLE:
                begin
                    if (xfer_req)
                    begin
                        bus_req <= 1'b1;
                        state   <= MP_REQ;
                    end
                end
                MP_REQ:
                begin
                    if (bus_grant)
                    begin
                        bus_out.util  <= 1'b1;
                        bus_out.sdata <= frame[FRAME_LEN-1];
                        bit_cnt       <= CNT_W'(1);
                        state         <= MP_SEND;
                    end
                end
                MP_SEND:
                begin
                    if (bit_cnt == CNT_W'(FRAME_LEN))
                    begin
                        bus_out  <= '0;             // Release the lines
                        bus_req  <= 1'b0;
                        xfer_ack <= 1'b1;
                        state    <= MP_ACK;
                    end
                    else
                    begin
                        bus_out.sdata <= shreg[FRAME_LEN-1];
                        bit_cnt       <= bit_cnt + 1'b1;
                    end
                end
                MP_ACK:
                begin
                    if (!xfer_req)
                    begin
                        xfer_ack <= 1'b0;
                        state    <= MP_IDLE;
                    end
                end
                default: state <= MP_IDLE;
            endcase
        end
    end

endmodule

//--- bus_arbiter.sv
/*
 * Bus arbiter
 * Round-robin four-phase arbitration between the external master and the node
 */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clk,
    input  logic rstn,
    input  logic ext_req,
    input  logic node_req,
    output logic ext_grant,
    output logic node_grant
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_EXT,
        OWN_NODE
    } owner_e;

    owner_e owner;
    logic   last_node;                      // Node was served last

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            owner     <= OWN_NONE;
            last_node <= 1'b0;
        end
        else
        begin
            case (owner)
                OWN_NONE:
                begin
                    // Tie goes to whoever was not served last
                    if (ext_req && (!node_req || last_node))
                    begin
                        owner     <= OWN_EXT;
                        last_node <= 1'b0;
                    end
                    else if (node_req)
                    begin
                        owner     <= OWN_NODE;
                        last_node <= 1'b1;
                    end
                end
                OWN_EXT:  if (!ext_req) owner <= OWN_NONE;
                OWN_NODE: if (!node_req) owner <= OWN_NONE;
                default:  owner <= OWN_NONE;
            endcase
        end
    end

    assign ext_grant  = (owner == OWN_EXT);
    assign node_grant = (owner == OWN_NODE);

endmodule

//--- disp_bus_pkg.sv
/*
 * Display bus types
 * Serial bus lines, write transfers, register writes, node config, segments
 */
`include "disp_bus_defines.svh"

package disp_bus_pkg;

    // One-wire bus with its utilization line
    typedef struct packed {
        logic util;                         // Frame in progress
        logic sdata;
    } sbus_t;

    typedef struct packed {
        logic [`DB_ADDR_W-1:0] addr;        // Node id in the top bits
        logic [`DB_DATA_W-1:0] data;
    } xfer_t;

    typedef struct packed {
        logic                  valid;
        logic [`DB_IDX_W-1:0]  index;
        logic [`DB_DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [`DB_HOLD_W-1:0] holdoff;
        logic [`DB_ID_W-1:0]   fwd_id;
    } node_cfg_t;

    typedef logic [6:0] seg_t;              // abcdefg, active high

    typedef seg_t [2:0] disp_digits_t;      // [0] is the ones digit

endpackage

//--- disp_bus_defines.svh
/*
 * Display bus node constants
 * Bus widths, frame length, node id, register map and reset defaults
 */
`ifndef DISP_BUS_DEFINES_SVH
`define DISP_BUS_DEFINES_SVH

// Bus geometry
`define DB_ADDR_W       15
`define DB_ID_W         3           // Upper address bits
`define DB_IDX_W        12          // Lower address bits
`define DB_DATA_W       8
`define DB_HOLD_W       8
`define DB_FRAME_LEN    23          // Address then data, MSB first

`define DB_SELF_ID      3'd0

// Reset defaults
`define DB_HOLDOFF_RST  8'd63
`define DB_FWD_ID_RST   3'd2

// Register map
`define DB_REG_DISP     12'd0
`define DB_REG_HOLDOFF  12'd1
`define DB_REG_FWD      12'd2

`endif
